// File: keystore_pkg.sv
`default_nettype none

package keystore_pkg;

   // Table geometry
   localparam int table_count    = 8;
   localparam int rows_per_table = 64;
   localparam int key_width      = 64;

   // Keys sent per pass before the row counter wraps
   localparam int stream_keys = 42;

   // Value returned by the version register
   localparam logic [31:0] version_word = 32'h00010007;

   // Byte address bits below this are ignored by the register decode
   localparam int reg_idx_lsb = 2;

   typedef logic [31:0]          axil_data_t;
   typedef logic [key_width-1:0] key_t;
   typedef logic [2:0]           table_sel_t;
   typedef logic [5:0]           row_t;
   // Table number in the upper bits, row in the lower bits
   typedef logic [8:0]           key_addr_t;
   typedef logic [3:0]           reg_idx_t;

   // Register map, as word indices
   localparam reg_idx_t reg_version    = 4'd0;
   localparam reg_idx_t reg_type       = 4'd1;
   localparam reg_idx_t reg_scratch    = 4'd2;
   localparam reg_idx_t reg_control    = 4'd3;
   localparam reg_idx_t reg_table_ctrl = 4'd8;
   localparam reg_idx_t reg_row_addr   = 4'd10;
   localparam reg_idx_t reg_data_h     = 4'd11;
   localparam reg_idx_t reg_data_l     = 4'd12;

   // Table control register bits
   localparam int ctrl_write_bit   = 0;
   localparam int ctrl_read_bit    = 1;
   localparam int ctrl_lockout_bit = 31;

   // Key streamer FSM
   typedef enum logic {
      stream_idle,
      stream_send
   } stream_state_t;

endpackage

`default_nettype wire

// File: reg_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if
   import keystore_pkg::*;
();

   // Write strobe, one cycle per accepted bus write
   logic       wr_en;
   reg_idx_t   wr_idx;
   axil_data_t wr_data;

   // Read select and combinational read data
   reg_idx_t   rd_idx;
   axil_data_t rd_data;

   // Bus side
   modport slave (output wr_en, wr_idx, wr_data, rd_idx, input rd_data);

   // Register file side
   modport regs (input wr_en, wr_idx, wr_data, rd_idx, output rd_data);

endinterface

`default_nettype wire

// File: table_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface table_port_if
   import keystore_pkg::*;
();

   // Access request from the register file
   logic      en;
   logic      we;
   key_addr_t addr;
   key_t      wdata;

   // Registered read data, valid the cycle after a read access
   key_t      rdata;

   // Requester side
   modport regs (output en, we, addr, wdata, input rdata);

   // Memory side
   modport ram (input en, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

// File: axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave
   import keystore_pkg::*;
(
   input  wire             s_axi_aclk,
   input  wire             s_axi_aresetn,
   // Write address and write data channels
   input  wire axil_data_t awaddr,
   input  wire             awvalid,
   output logic            awready,
   input  wire axil_data_t wdata,
   input  wire             wvalid,
   output logic            wready,
   // Write response channel
   output logic [1:0]      bresp,
   output logic            bvalid,
   input  wire             bready,
   // Read address channel
   input  wire axil_data_t araddr,
   input  wire             arvalid,
   output logic            arready,
   // Read data channel
   output axil_data_t      rdata,
   output logic [1:0]      rresp,
   output logic            rvalid,
   input  wire             rready,
   // Register file side
   reg_bus_if.slave        bus
);

   logic     wr_accept;
   logic     wr_fire;
   logic     rd_fire;
   reg_idx_t aw_idx;
   reg_idx_t ar_idx;

   // Address and data are taken together in one accept cycle
   assign awready = wr_accept;
   assign wready  = wr_accept;
   assign wr_fire = wr_accept && awvalid && wvalid;

   // Read data is captured when the address handshake completes
   assign rd_fire = arready && arvalid && !rvalid;

   // Always OKAY
   assign bresp = 2'b00;
   assign rresp = 2'b00;

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         wr_accept <= 1'b0;
         bvalid    <= 1'b0;
      end else begin
         // One-cycle ready pulse, held off while a response is pending
         wr_accept <= !wr_accept && awvalid && wvalid && !bvalid;
         if (wr_fire && !bvalid) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rdata   <= '0;
      end else begin
         // No new read address while the previous data waits for rready
         arready <= !arready && arvalid && !rvalid;
         if (rd_fire) begin
            rvalid <= 1'b1;
            rdata  <= bus.rd_data;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // Latch the word index of each bus address
   always_ff @(posedge s_axi_aclk) begin
      if (!wr_accept && awvalid && wvalid) begin
         aw_idx <= awaddr[reg_idx_lsb +: $bits(reg_idx_t)];
      end
      if (!arready && arvalid) begin
         ar_idx <= araddr[reg_idx_lsb +: $bits(reg_idx_t)];
      end
   end

   // Write strobe lands in the accept cycle, data is still on the bus
   assign bus.wr_en   = wr_fire;
   assign bus.wr_idx  = aw_idx;
   assign bus.wr_data = wdata;
   assign bus.rd_idx  = ar_idx;

   // Responses stay up until the master takes them
   a_bvalid_hold : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      bvalid && !bready |=> bvalid);

   a_rvalid_hold : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// File: keystore_regs.sv
`timescale 1ns/1ps
`default_nettype none

module keystore_regs
   import keystore_pkg::*;
(
   input  wire        s_axi_aclk,
   input  wire        s_axi_aresetn,
   reg_bus_if.regs    bus,
   table_port_if.regs tbl,
   output logic       stream_enable
);

   axil_data_t scratch;
   logic       ctrl_enable;
   logic       tc_write;
   logic       tc_read;
   logic       lockout;
   table_sel_t tbl_sel;
   row_t       tbl_row;
   axil_data_t data_h;
   axil_data_t data_l;
   logic       access;
   axil_data_t table_ctrl_word;

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         scratch     <= '0;
         ctrl_enable <= 1'b0;
         tc_write    <= 1'b0;
         tc_read     <= 1'b0;
         lockout     <= 1'b0;
         tbl_sel     <= '0;
         tbl_row     <= '0;
         access      <= 1'b0;
      end else begin
         // Row address write starts one table access in the next cycle
         access <= bus.wr_en && (bus.wr_idx == reg_row_addr);
         if (bus.wr_en) begin
            case (bus.wr_idx)
               reg_scratch: scratch <= bus.wr_data;
               // Bit 0 enables the key stream
               reg_control: ctrl_enable <= bus.wr_data[0];
               reg_table_ctrl: begin
                  tc_write <= bus.wr_data[ctrl_write_bit];
                  tc_read  <= bus.wr_data[ctrl_read_bit];
                  // Lockout can only be set
                  lockout  <= lockout || bus.wr_data[ctrl_lockout_bit];
               end
               reg_row_addr: begin
                  // Row in bits 7:0, table in bits 15:8
                  tbl_row <= bus.wr_data[0 +: $bits(row_t)];
                  tbl_sel <= bus.wr_data[8 +: $bits(table_sel_t)];
               end
               default: ;
            endcase
         end
      end
   end

   // Key halves staged for a table write
   always_ff @(posedge s_axi_aclk) begin
      if (bus.wr_en && (bus.wr_idx == reg_data_h)) begin
         data_h <= bus.wr_data;
      end
      if (bus.wr_en && (bus.wr_idx == reg_data_l)) begin
         data_l <= bus.wr_data;
      end
   end

   // Read wins when both bits are set
   assign tbl.en    = access && (tc_write || tc_read) && !lockout;
   assign tbl.we    = tc_write && !tc_read;
   assign tbl.addr  = {tbl_sel, tbl_row};
   assign tbl.wdata = {data_h, data_l};

   assign stream_enable = ctrl_enable;

   always_comb begin
      table_ctrl_word                   = '0;
      table_ctrl_word[ctrl_write_bit]   = tc_write;
      table_ctrl_word[ctrl_read_bit]    = tc_read;
      table_ctrl_word[ctrl_lockout_bit] = lockout;
   end

   // Read decode, the old status offset falls into the zero default
   always_comb begin
      case (bus.rd_idx)
         reg_version:    bus.rd_data = version_word;
         reg_type:       bus.rd_data = {16'd0, 8'(table_count), 8'(rows_per_table)};
         reg_scratch:    bus.rd_data = scratch;
         reg_control:    bus.rd_data = {31'd0, ctrl_enable};
         reg_table_ctrl: bus.rd_data = table_ctrl_word;
         reg_row_addr:   bus.rd_data = {21'd0, tbl_sel, 2'd0, tbl_row};
         // Key halves hidden once lockout is set
         reg_data_h:     bus.rd_data = lockout ? '0 : tbl.rdata[63:32];
         reg_data_l:     bus.rd_data = lockout ? '0 : tbl.rdata[31:0];
         default:        bus.rd_data = '0;
      endcase
   end

   // Lockout holds from the first set until the next reset
   a_lockout_sticky : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      lockout |=> lockout);

endmodule

`default_nettype wire

// File: key_table_ram.sv
`timescale 1ns/1ps
`default_nettype none

module key_table_ram
   import keystore_pkg::*;
(
   input  wire            s_axi_aclk,
   table_port_if.ram      tbl,
   input  wire key_addr_t rd_addr,
   output key_t           rd_key
);

   // All tables back to back, indexed by {table, row}
   key_t mem [table_count*rows_per_table];

   // Register access port
   always_ff @(posedge s_axi_aclk) begin
      if (tbl.en) begin
         if (tbl.we) begin
            mem[tbl.addr] <= tbl.wdata;
         end else begin
            // Holds until the next read access
            tbl.rdata <= mem[tbl.addr];
         end
      end
   end

   // Stream port, read every cycle
   always_ff @(posedge s_axi_aclk) begin
      rd_key <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: key_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module key_streamer
   import keystore_pkg::*;
(
   input  wire             s_axi_aclk,
   input  wire             s_axi_aresetn,
   input  wire             stream_enable,
   input  wire             start_key_transmit,
   input  wire table_sel_t key_sel,
   output key_addr_t       rd_addr,
   input  wire key_t       rd_key,
   output key_t            tdata,
   output logic [7:0]      tuser,
   output logic            tlast,
   output logic            tvalid,
   input  wire             tready
);

   stream_state_t state;
   row_t          row;
   row_t          row_nxt;
   row_t          beat_row;
   logic          beat_valid;
   logic          at_last;
   logic          load;

   assign at_last = (row == row_t'(stream_keys - 1));

   // Output register takes the in-flight key when free or being drained
   always_comb begin
      if (state == stream_send) begin
         load = stream_enable && !start_key_transmit && (!beat_valid || tready);
      end else begin
         load = stream_enable && !start_key_transmit;
      end
   end

   always_comb begin
      if (start_key_transmit) begin
         row_nxt = '0;
      end else if (load) begin
         row_nxt = at_last ? '0 : row + 1'b1;
      end else begin
         row_nxt = row;
      end
   end

   // RAM reads the next row, so rd_key always belongs to row
   // Address holds during a stall
   assign rd_addr = {key_sel, row_nxt};

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         state      <= stream_idle;
         row        <= '0;
         beat_valid <= 1'b0;
      end else begin
         row <= row_nxt;
         case (state)
            stream_idle: begin
               if (load) begin
                  state      <= stream_send;
                  beat_valid <= 1'b1;
               end
            end
            stream_send: begin
               if (start_key_transmit) begin
                  state      <= stream_idle;
                  beat_valid <= 1'b0;
               end else if (load) begin
                  beat_valid <= 1'b1;
               end else if (!beat_valid || tready) begin
                  // Enable cleared and the last beat is gone
                  state      <= stream_idle;
                  beat_valid <= 1'b0;
               end
            end
         endcase
      end
   end

   // Beat payload
   always_ff @(posedge s_axi_aclk) begin
      if (load) begin
         tdata    <= rd_key;
         beat_row <= row;
         tlast    <= at_last;
      end
   end

   assign tuser = {2'b00, beat_row};
   // Restart pulse masks the beat at once
   assign tvalid = beat_valid && !start_key_transmit;

   a_beat_stable : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      tvalid && !tready |=> $stable(tdata) && $stable(tuser) && $stable(tlast));

endmodule

`default_nettype wire

// File: keystore.sv
`timescale 1ns/1ps
`default_nettype none

module keystore
   import keystore_pkg::*;
(
   input  wire              s_axi_aclk,
   input  wire              s_axi_aresetn,
   // AXI4-Lite slave
   input  wire axil_data_t  s_axi_awaddr,
   input  wire              s_axi_awvalid,
   output wire              s_axi_awready,
   input  wire axil_data_t  s_axi_wdata,
   input  wire              s_axi_wvalid,
   output wire              s_axi_wready,
   output wire [1:0]        s_axi_bresp,
   output wire              s_axi_bvalid,
   input  wire              s_axi_bready,
   input  wire axil_data_t  s_axi_araddr,
   input  wire              s_axi_arvalid,
   output wire              s_axi_arready,
   output wire axil_data_t  s_axi_rdata,
   output wire [1:0]        s_axi_rresp,
   output wire              s_axi_rvalid,
   input  wire              s_axi_rready,
   // AXI4-Stream key output
   output wire key_t        m_axis_keys_tdata,
   output wire [7:0]        m_axis_keys_tuser,
   output wire              m_axis_keys_tlast,
   output wire              m_axis_keys_tvalid,
   input  wire              m_axis_keys_tready,
   // Stream control
   input  wire              start_key_transmit,
   input  wire table_sel_t  reg_key_sel
);

   wire            stream_enable;
   wire key_addr_t rd_addr;
   wire key_t      rd_key;

   reg_bus_if    bus_if ();
   table_port_if tbl_if ();

   axil_slave axil_slave_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .awaddr        (s_axi_awaddr),
      .awvalid       (s_axi_awvalid),
      .awready       (s_axi_awready),
      .wdata         (s_axi_wdata),
      .wvalid        (s_axi_wvalid),
      .wready        (s_axi_wready),
      .bresp         (s_axi_bresp),
      .bvalid        (s_axi_bvalid),
      .bready        (s_axi_bready),
      .araddr        (s_axi_araddr),
      .arvalid       (s_axi_arvalid),
      .arready       (s_axi_arready),
      .rdata         (s_axi_rdata),
      .rresp         (s_axi_rresp),
      .rvalid        (s_axi_rvalid),
      .rready        (s_axi_rready),
      .bus           (bus_if.slave)
   );

   keystore_regs keystore_regs_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .bus           (bus_if.regs),
      .tbl           (tbl_if.regs),
      .stream_enable (stream_enable)
   );

   key_table_ram key_table_ram_i (
      .s_axi_aclk (s_axi_aclk),
      .tbl        (tbl_if.ram),
      .rd_addr    (rd_addr),
      .rd_key     (rd_key)
   );

   key_streamer key_streamer_i (
      .s_axi_aclk         (s_axi_aclk),
      .s_axi_aresetn      (s_axi_aresetn),
      .stream_enable      (stream_enable),
      .start_key_transmit (start_key_transmit),
      .key_sel            (reg_key_sel),
      .rd_addr            (rd_addr),
      .rd_key             (rd_key),
      .tdata              (m_axis_keys_tdata),
      .tuser              (m_axis_keys_tuser),
      .tlast              (m_axis_keys_tlast),
      .tvalid             (m_axis_keys_tvalid),
      .tready             (m_axis_keys_tready)
   );

endmodule

`default_nettype wire

// File: tb_keystore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_keystore
   import keystore_pkg::*;
();

   localparam int last_row = 41;
   localparam int max_steps = 40;

   // Operations that the stimulus table can hold
   typedef enum logic [2:0] {
      op_write, op_read, op_key_write, op_key_read, op_fill, op_stream, op_lockout
   } op_t;

   typedef struct packed {
      op_t        op;
      reg_idx_t   idx;
      axil_data_t value;
      table_sel_t tbl;
      row_t       row;
   } step_t;

   logic       s_axi_aclk;
   logic       s_axi_aresetn;
   axil_data_t s_axi_awaddr;
   logic       s_axi_awvalid;
   logic       s_axi_awready;
   axil_data_t s_axi_wdata;
   logic       s_axi_wvalid;
   logic       s_axi_wready;
   logic [1:0] s_axi_bresp;
   logic       s_axi_bvalid;
   logic       s_axi_bready;
   axil_data_t s_axi_araddr;
   logic       s_axi_arvalid;
   logic       s_axi_arready;
   axil_data_t s_axi_rdata;
   logic [1:0] s_axi_rresp;
   logic       s_axi_rvalid;
   logic       s_axi_rready;
   key_t       m_axis_keys_tdata;
   logic [7:0] m_axis_keys_tuser;
   logic       m_axis_keys_tlast;
   logic       m_axis_keys_tvalid;
   logic       m_axis_keys_tready;
   logic       start_key_transmit;
   table_sel_t reg_key_sel;

   step_t  steps [0:max_steps-1];
   int     step_count;
   key_t   model [0:511];
   logic   locked;
   int     errors;
   integer seed;
   int     i;

   keystore dut_i (.*);

   initial begin
      s_axi_aclk = 1'b0;
      forever #4 s_axi_aclk = ~s_axi_aclk;
   end

   // Hang guard sized from the stimulus table once it is built
   initial begin
      #1;
      repeat (step_count * 200) @(posedge s_axi_aclk);
      $display("Timeout: run did not finish after %0d cycles, %0d errors so far",
               step_count * 200, errors);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("ERROR t=%0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("Failure at t=%0t: %s", $time, msg);
      errors++;
   endtask

   task automatic add_step(input op_t op, input reg_idx_t idx, input axil_data_t value,
                           input table_sel_t tbl, input row_t row);
      steps[step_count] = '{op, idx, value, tbl, row};
      step_count++;
   endtask

   // Both channels driven at once and the response taken with bready held high
   task automatic bus_write(input reg_idx_t idx, input axil_data_t val);
      s_axi_awaddr  = {26'd0, idx, 2'b00};
      s_axi_wdata   = val;
      s_axi_awvalid = 1'b1;
      s_axi_wvalid  = 1'b1;
      do begin
         @(posedge s_axi_aclk);
         #1;
      end while (!s_axi_awready);
      // Address and data accepted together
      if (s_axi_wready !== 1'b1) report_mismatch("s_axi_wready", 1'b1, s_axi_wready);
      // Handshake happens on this edge
      @(posedge s_axi_aclk);
      #1;
      s_axi_awvalid = 1'b0;
      s_axi_wvalid  = 1'b0;
      // Ready is a single-cycle pulse
      if (s_axi_awready !== 1'b0) report_mismatch("s_axi_awready", 1'b0, s_axi_awready);
      if (s_axi_wready !== 1'b0) report_mismatch("s_axi_wready", 1'b0, s_axi_wready);
      while (!s_axi_bvalid) begin
         @(posedge s_axi_aclk);
         #1;
      end
      if (s_axi_bresp !== 2'b00) report_mismatch("s_axi_bresp", 2'b00, s_axi_bresp);
      @(posedge s_axi_aclk);
      #1;
   endtask

   task automatic bus_read(input reg_idx_t idx, output axil_data_t val);
      s_axi_araddr  = {26'd0, idx, 2'b00};
      s_axi_arvalid = 1'b1;
      do begin
         @(posedge s_axi_aclk);
         #1;
      end while (!s_axi_arready);
      @(posedge s_axi_aclk);
      #1;
      s_axi_arvalid = 1'b0;
      while (!s_axi_rvalid) begin
         @(posedge s_axi_aclk);
         #1;
      end
      val = s_axi_rdata;
      if (s_axi_rresp !== 2'b00) report_mismatch("s_axi_rresp", 2'b00, s_axi_rresp);
      @(posedge s_axi_aclk);
      #1;
   endtask

   // Data halves and control word go first and the row address write fires the access
   task automatic write_key(input table_sel_t tsel, input row_t row, input key_t key);
      bus_write(reg_data_h, key[63:32]);
      bus_write(reg_data_l, key[31:0]);
      bus_write(reg_table_ctrl, 32'h0000_0001);
      bus_write(reg_row_addr, {21'd0, tsel, 2'd0, row});
      // Locked table keeps its old contents
      if (!locked) model[{tsel, row}] = key;
   endtask

   task automatic read_key(input table_sel_t tsel, input row_t row);
      axil_data_t got;
      key_t       expected;
      expected = locked ? '0 : model[{tsel, row}];
      bus_write(reg_table_ctrl, 32'h0000_0002);
      bus_write(reg_row_addr, {21'd0, tsel, 2'd0, row});
      bus_read(reg_data_h, got);
      if (got !== expected[63:32]) report_mismatch("data_h", expected[63:32], got);
      bus_read(reg_data_l, got);
      if (got !== expected[31:0]) report_mismatch("data_l", expected[31:0], got);
   endtask

   task automatic random_key(output key_t key);
      axil_data_t upper;
      axil_data_t lower;
      upper = $random(seed);
      lower = $random(seed);
      key   = {upper, lower};
   endtask

   task automatic check_stream(input table_sel_t tsel, input int nbeats);
      int         seen;
      row_t       exp_row;
      logic       stalled;
      key_t       held_data;
      logic [7:0] held_user;
      logic       held_last;
      key_t       exp_key;
      seen    = 0;
      exp_row = '0;
      stalled = 1'b0;
      m_axis_keys_tready = 1'b0;
      reg_key_sel = tsel;
      bus_write(reg_control, 32'h0000_0001);
      start_key_transmit = 1'b1;
      // Sample once the restart has settled
      #1;
      if (m_axis_keys_tvalid !== 1'b0)
         report_failure("tvalid high while start_key_transmit is high");
      @(posedge s_axi_aclk);
      #1;
      start_key_transmit = 1'b0;
      while (seen < nbeats) begin
         // Beat held back last cycle must not move
         if (stalled) begin
            if (!m_axis_keys_tvalid) report_failure("tvalid dropped during a stall");
            if (m_axis_keys_tdata !== held_data)
               report_mismatch("m_axis_keys_tdata", held_data, m_axis_keys_tdata);
            if (m_axis_keys_tuser !== held_user)
               report_mismatch("m_axis_keys_tuser", held_user, m_axis_keys_tuser);
            if (m_axis_keys_tlast !== held_last)
               report_mismatch("m_axis_keys_tlast", held_last, m_axis_keys_tlast);
         end
         // Roughly three out of four cycles ready
         m_axis_keys_tready = (($random(seed) & 3) != 0);
         stalled = 1'b0;
         if (m_axis_keys_tvalid && m_axis_keys_tready) begin
            exp_key = model[{tsel, exp_row}];
            if (m_axis_keys_tuser !== {2'b00, exp_row})
               report_mismatch("m_axis_keys_tuser", {2'b00, exp_row}, m_axis_keys_tuser);
            if (m_axis_keys_tdata !== exp_key)
               report_mismatch("m_axis_keys_tdata", exp_key, m_axis_keys_tdata);
            if (m_axis_keys_tlast !== (exp_row == last_row))
               report_mismatch("m_axis_keys_tlast", exp_row == last_row, m_axis_keys_tlast);
            exp_row = (exp_row == last_row) ? '0 : exp_row + 1'b1;
            seen++;
         end else if (m_axis_keys_tvalid) begin
            stalled   = 1'b1;
            held_data = m_axis_keys_tdata;
            held_user = m_axis_keys_tuser;
            held_last = m_axis_keys_tlast;
         end
         @(posedge s_axi_aclk);
         #1;
      end
      // Let the stream drain and stop
      m_axis_keys_tready = 1'b1;
      bus_write(reg_control, 32'h0000_0000);
   endtask

   task automatic apply_step(input step_t s);
      axil_data_t got;
      key_t       key;
      case (s.op)
         op_write: bus_write(s.idx, s.value);
         op_read: begin
            bus_read(s.idx, got);
            if (got !== s.value) report_mismatch("s_axi_rdata", s.value, got);
         end
         op_key_write: begin
            random_key(key);
            write_key(s.tbl, s.row, key);
         end
         op_key_read: read_key(s.tbl, s.row);
         op_fill: begin
            for (int r = 0; r <= last_row; r++) begin
               random_key(key);
               write_key(s.tbl, row_t'(r), key);
            end
         end
         op_stream: check_stream(s.tbl, s.value);
         op_lockout: begin
            bus_write(reg_table_ctrl, 32'h8000_0000);
            locked = 1'b1;
         end
         default: report_failure("unknown operation in stimulus table");
      endcase
   endtask

   task automatic build_steps();
      table_sel_t t;
      row_t       r;
      add_step(op_read, reg_version, 32'h0001_0007, '0, '0);
      // 64 rows in bits 7:0, 8 tables in bits 15:8
      add_step(op_read, reg_type, 32'h0000_0840, '0, '0);
      add_step(op_write, reg_scratch, 32'ha5c3_1e77, '0, '0);
      add_step(op_read, reg_scratch, 32'ha5c3_1e77, '0, '0);
      add_step(op_write, reg_control, 32'h0000_0001, '0, '0);
      add_step(op_read, reg_control, 32'h0000_0001, '0, '0);
      add_step(op_write, reg_control, 32'h0000_0000, '0, '0);
      add_step(op_read, reg_control, 32'h0000_0000, '0, '0);
      add_step(op_read, reg_table_ctrl, 32'h0000_0000, '0, '0);
      add_step(op_fill, '0, '0, 3'd5, '0);
      for (int k = 0; k < 4; k++) begin
         t = $random(seed);
         r = $random(seed);
         add_step(op_key_write, '0, '0, t, r);
         add_step(op_key_read, '0, '0, t, r);
      end
      add_step(op_stream, '0, 32'd50, 3'd5, '0);
      add_step(op_key_read, '0, '0, 3'd5, 6'd0);
      add_step(op_lockout, '0, '0, '0, '0);
      add_step(op_read, reg_table_ctrl, 32'h8000_0000, '0, '0);
      // Clearing bit 31 has no effect
      add_step(op_write, reg_table_ctrl, 32'h0000_0000, '0, '0);
      add_step(op_read, reg_table_ctrl, 32'h8000_0000, '0, '0);
      add_step(op_key_read, '0, '0, 3'd5, 6'd3);
      add_step(op_key_write, '0, '0, 3'd5, 6'd3);
      add_step(op_stream, '0, 32'd50, 3'd5, '0);
   endtask

   initial begin
      seed       = 32'hab34;
      errors     = 0;
      locked     = 1'b0;
      step_count = 0;
      s_axi_aresetn      = 1'b0;
      s_axi_awaddr       = '0;
      s_axi_awvalid      = 1'b0;
      s_axi_wdata        = '0;
      s_axi_wvalid       = 1'b0;
      s_axi_bready       = 1'b1;
      s_axi_araddr       = '0;
      s_axi_arvalid      = 1'b0;
      s_axi_rready       = 1'b1;
      m_axis_keys_tready = 1'b1;
      start_key_transmit = 1'b0;
      reg_key_sel        = '0;
      build_steps();
      repeat (4) @(posedge s_axi_aclk);
      #1;
      s_axi_aresetn = 1'b1;
      // Everything idle straight out of reset
      if ({s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_arready, s_axi_rvalid,
           m_axis_keys_tvalid} !== 6'b0)
         report_failure("handshake outputs not low after reset");
      if (s_axi_rdata !== 32'h0) report_mismatch("s_axi_rdata", 32'h0, s_axi_rdata);
      for (i = 0; i < step_count; i++) begin
         apply_step(steps[i]);
      end
      $display("Run finished after %0d steps, %0d errors", step_count, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: keystore.f
keystore_pkg.sv
reg_bus_if.sv
table_port_if.sv
axil_slave.sv
keystore_regs.sv
key_table_ram.sv
key_streamer.sv
keystore.sv
tb_keystore.sv

// File: Bender.yml
package:
  name: keystore

sources:
  - keystore_pkg.sv
  - reg_bus_if.sv
  - table_port_if.sv
  - axil_slave.sv
  - keystore_regs.sv
  - key_table_ram.sv
  - key_streamer.sv
  - keystore.sv
  - target: test
    files:
      - tb_keystore.sv
